// ==== build.f ====
+incdir+.
crc_ahb_pkg.sv
crc_input_buffer.sv
crc_unit.sv
crc_host_interface.sv
crc_ahb_top.sv
tb_crc_ahb.sv

// ==== crc_ahb_pkg.sv ====
/*
  Shared types and register map of the AHB-Lite CRC peripheral
  CR fields sit at bits 7 to 3, so crc_cfg_t is declared MSB first
*/
package crc_ahb_pkg;

	//////////////////////////////////////////////////////////////////////
	// Bus words and register map
	//////////////////////////////////////////////////////////////////////

	typedef logic [31:0] crc_word_t;

	// Word index taken from HADDR[4:2]
	localparam logic [2:0] CRC_DR   = 3'd0;
	localparam logic [2:0] CRC_IDR  = 3'd1;
	localparam logic [2:0] CRC_CR   = 3'd2;
	localparam logic [2:0] CRC_INIT = 3'd4;
	localparam logic [2:0] CRC_POL  = 3'd5;

	// AHB encodings in use
	localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
	localparam logic       HRESP_OKAY    = 1'b0;

	//////////////////////////////////////////////////////////////////////
	// Control register fields
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		POLY_32 = 2'd0,
		POLY_16 = 2'd1,
		POLY_8  = 2'd2,
		POLY_7  = 2'd3
	} crc_poly_size_e;

	// Bit reversal of input data before it enters the engine
	typedef enum logic [1:0] {
		REV_NONE = 2'd0,
		REV_BYTE = 2'd1,
		REV_HALF = 2'd2,
		REV_WORD = 2'd3
	} crc_rev_in_e;

	// Data write size, low two bits of HSIZE
	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2
	} crc_bus_size_e;

	// CR[7] rev_out, CR[6:5] rev_in, CR[4:3] poly_size
	typedef struct packed {
		logic           rev_out;
		crc_rev_in_e    rev_in;
		crc_poly_size_e poly_size;
	} crc_cfg_t;

	//////////////////////////////////////////////////////////////////////
	// Input buffer entry
	//////////////////////////////////////////////////////////////////////

	// Stored as a word, consumed byte by byte
	typedef union packed {
		crc_word_t       word;
		logic [3:0][7:0] bytes;
	} crc_data_u;

	typedef struct packed {
		crc_data_u     data;
		crc_bus_size_e size;
	} crc_entry_t;

	// Register values after reset
	localparam crc_word_t  CRC_POLY_RESET = 32'h04C1_1DB7;
	localparam crc_word_t  CRC_INIT_RESET = 32'hFFFF_FFFF;
	localparam logic [7:0] CRC_IDR_RESET  = 8'h00;

endpackage

// ==== crc_ahb_top.sv ====
/*
  AHB-Lite CRC peripheral, BUF_DEPTH sets the number of queued DR writes
*/
`timescale 1ns/1ps

module crc_ahb_top
#(
	parameter int BUF_DEPTH = 2
)
(
	input  logic                   HCLK,
	input  logic                   HRESETn,
	input  logic                   HSElx,
	input  crc_ahb_pkg::crc_word_t HADDR,
	input  logic [1:0]             HTRANS,
	input  logic                   HWRITE,
	input  logic [2:0]             HSIZE,
	input  crc_ahb_pkg::crc_word_t HWDATA,
	input  logic                   HREADY,
	output crc_ahb_pkg::crc_word_t HRDATA,
	output logic                   HREADYOUT,
	output logic                   HRESP
);

	import crc_ahb_pkg::*;

	// Host interface to CRC unit
	crc_cfg_t      cfg;
	crc_word_t     bus_wr;
	crc_bus_size_e bus_size;
	logic          crc_init_en;
	logic          crc_idr_en;
	logic          crc_poly_en;
	logic          reset_chain;
	crc_word_t     crc_out;
	crc_word_t     crc_init_out;
	crc_word_t     crc_poly_out;
	logic [7:0]    crc_idr_out;
	logic          reset_pending;
	logic          read_wait;

	// Buffer side
	logic       buffer_write_en;
	logic       buffer_full;
	logic       buffer_empty;
	logic       pop;
	crc_entry_t push_entry;
	crc_entry_t head;

	// Entry layout is data word above the size field
	assign push_entry = crc_entry_t'({bus_wr, bus_size});

	crc_host_interface u_host_interface
	(
		.HCLK            (HCLK),
		.HRESETn         (HRESETn),
		.HSElx           (HSElx),
		.HADDR           (HADDR),
		.HTRANS          (HTRANS),
		.HWRITE          (HWRITE),
		.HSIZE           (HSIZE),
		.HWDATA          (HWDATA),
		.HREADY          (HREADY),
		.crc_out         (crc_out),
		.crc_init_out    (crc_init_out),
		.crc_poly_out    (crc_poly_out),
		.crc_idr_out     (crc_idr_out),
		.buffer_full     (buffer_full),
		.reset_pending   (reset_pending),
		.read_wait       (read_wait),
		.HRDATA          (HRDATA),
		.HREADYOUT       (HREADYOUT),
		.HRESP           (HRESP),
		.bus_wr          (bus_wr),
		.bus_size        (bus_size),
		.cfg             (cfg),
		.crc_init_en     (crc_init_en),
		.crc_idr_en      (crc_idr_en),
		.crc_poly_en     (crc_poly_en),
		.buffer_write_en (buffer_write_en),
		.reset_chain     (reset_chain)
	);

	// reset_chain also empties the queue
	crc_input_buffer #(
		.BUF_DEPTH (BUF_DEPTH)
	) u_input_buffer
	(
		.HCLK         (HCLK),
		.HRESETn      (HRESETn),
		.push         (buffer_write_en),
		.push_entry   (push_entry),
		.pop          (pop),
		.flush        (reset_chain),
		.head         (head),
		.buffer_full  (buffer_full),
		.buffer_empty (buffer_empty)
	);

	crc_unit u_crc_unit
	(
		.HCLK          (HCLK),
		.HRESETn       (HRESETn),
		.cfg           (cfg),
		.bus_wr        (bus_wr),
		.crc_init_en   (crc_init_en),
		.crc_idr_en    (crc_idr_en),
		.crc_poly_en   (crc_poly_en),
		.reset_chain   (reset_chain),
		.head          (head),
		.buffer_empty  (buffer_empty),
		.pop           (pop),
		.crc_out       (crc_out),
		.crc_init_out  (crc_init_out),
		.crc_poly_out  (crc_poly_out),
		.crc_idr_out   (crc_idr_out),
		.reset_pending (reset_pending),
		.read_wait     (read_wait)
	);

endmodule

// ==== crc_host_interface.sv ====
/*
  AHB-Lite slave front end with HRESP always OKAY and wait states through HREADYOUT
  Only NONSEQ transfers count, and HADDR[1:0] is ignored
*/
`timescale 1ns/1ps

module crc_host_interface
(
	input  logic                          HCLK,
	input  logic                          HRESETn,
	input  logic                          HSElx,
	input  crc_ahb_pkg::crc_word_t        HADDR,
	input  logic [1:0]                    HTRANS,
	input  logic                          HWRITE,
	input  logic [2:0]                    HSIZE,
	input  crc_ahb_pkg::crc_word_t        HWDATA,
	input  logic                          HREADY,
	input  crc_ahb_pkg::crc_word_t        crc_out,
	input  crc_ahb_pkg::crc_word_t        crc_init_out,
	input  crc_ahb_pkg::crc_word_t        crc_poly_out,
	input  logic [7:0]                    crc_idr_out,
	input  logic                          buffer_full,
	input  logic                          reset_pending,
	input  logic                          read_wait,
	output crc_ahb_pkg::crc_word_t        HRDATA,
	output logic                          HREADYOUT,
	output logic                          HRESP,
	output crc_ahb_pkg::crc_word_t        bus_wr,
	output crc_ahb_pkg::crc_bus_size_e    bus_size,
	output crc_ahb_pkg::crc_cfg_t         cfg,
	output logic                          crc_init_en,
	output logic                          crc_idr_en,
	output logic                          crc_poly_en,
	output logic                          buffer_write_en,
	output logic                          reset_chain
);

	import crc_ahb_pkg::*;

	// Address phase copies
	logic [2:0]    addr_q;
	crc_bus_size_e size_q;
	logic          sel_q;
	logic          write_q;
	logic          nonseq_q;

	// Five-bit control register
	crc_cfg_t cfg_q;

	logic sample_bus;
	logic active;
	logic wr_active;
	logic rd_active;
	logic dr_wr;
	logic dr_rd;
	logic init_wr;
	logic cr_wr;

	//////////////////////////////////////////////////////////////////////
	// Address phase pipeline
	//////////////////////////////////////////////////////////////////////

	// Bus is sampled only when nobody stalls
	assign sample_bus = HREADY && HREADYOUT;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			sel_q    <= 1'b0;
			write_q  <= 1'b0;
			nonseq_q <= 1'b0;
		end
		else if (sample_bus)
		begin
			sel_q    <= HSElx;
			write_q  <= HWRITE;
			nonseq_q <= (HTRANS == HTRANS_NONSEQ);
		end
	end

	// Address and size of the sampled transfer
	always_ff @(posedge HCLK)
	begin
		if (sample_bus)
		begin
			addr_q <= HADDR[4:2];
			// Anything wider than a word is treated as a word
			size_q <= (HSIZE[2] || HSIZE[1]) ? SIZE_WORD : crc_bus_size_e'(HSIZE[1:0]);
		end
	end

	// Data phase qualifiers
	assign active    = sel_q && nonseq_q;
	assign wr_active = active && write_q;
	assign rd_active = active && !write_q;

	assign dr_wr   = wr_active && (addr_q == CRC_DR);
	assign dr_rd   = rd_active && (addr_q == CRC_DR);
	assign init_wr = wr_active && (addr_q == CRC_INIT);
	assign cr_wr   = wr_active && (addr_q == CRC_CR);

	// Strobes fire only on the last cycle of a data phase
	assign buffer_write_en = dr_wr && !buffer_full;
	assign crc_init_en     = init_wr && !reset_pending;
	assign crc_idr_en      = wr_active && (addr_q == CRC_IDR);
	assign crc_poly_en     = wr_active && (addr_q == CRC_POL);

	// Write data straight from the bus and size from the pipeline
	assign bus_wr   = HWDATA;
	assign bus_size = size_q;

	//////////////////////////////////////////////////////////////////////
	// Control register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			cfg_q <= '0;
		else if (cr_wr)
			cfg_q <= crc_cfg_t'(HWDATA[7:3]);
	end

	assign cfg = cfg_q;

	// Self-clearing CR bit 0 restarts the CRC chain
	assign reset_chain = cr_wr && HWDATA[0];

	// Stall on full buffer, pending DR read, or INIT update behind data
	assign HREADYOUT = !((dr_wr && buffer_full) ||
	                     (dr_rd && read_wait) ||
	                     (init_wr && reset_pending));

	assign HRESP = HRESP_OKAY;

	// Combinational read mux during the data phase
	always_comb
	begin
		case (addr_q)
			CRC_DR:   HRDATA = crc_out;
			CRC_IDR:  HRDATA = {24'h0, crc_idr_out};
			CRC_CR:   HRDATA = {24'h0, cfg_q, 3'b000};
			CRC_INIT: HRDATA = crc_init_out;
			CRC_POL:  HRDATA = crc_poly_out;
			default:  HRDATA = '0;
		endcase
	end

	// A sampled phase that is no selected NONSEQ write gives no strobe next cycle
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		sample_bus && !(HSElx && HWRITE && HTRANS == HTRANS_NONSEQ)
		|=> !(crc_init_en || crc_idr_en || crc_poly_en || buffer_write_en || reset_chain));

	// Idle or unselected address phase never stalls its data phase
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		sample_bus && !(HSElx && HTRANS == HTRANS_NONSEQ) |=> HREADYOUT);

endmodule

// ==== crc_input_buffer.sv ====
/*
  Circular FIFO of pending DR writes, any depth from 1 up
  The host stalls instead of pushing into a full buffer
*/
`timescale 1ns/1ps

module crc_input_buffer
#(
	parameter int BUF_DEPTH = 2
)
(
	input  logic                   HCLK,
	input  logic                   HRESETn,
	input  logic                   push,
	input  crc_ahb_pkg::crc_entry_t push_entry,
	input  logic                   pop,
	input  logic                   flush,
	output crc_ahb_pkg::crc_entry_t head,
	output logic                   buffer_full,
	output logic                   buffer_empty
);

	import crc_ahb_pkg::*;

	// A one-deep FIFO still needs a one-bit pointer
	localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
	localparam int CNT_W = $clog2(BUF_DEPTH + 1);

	crc_entry_t       mem [BUF_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	assign buffer_empty = (count == '0);
	assign buffer_full  = (count == CNT_W'(BUF_DEPTH));
	assign head         = mem[rd_ptr];

	// Storage
	always_ff @(posedge HCLK)
	begin
		if (push)
			mem[wr_ptr] <= push_entry;
	end

	// Pointers and occupancy, flush drops everything queued
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn || flush)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// Host must hold the DR write while full
	assert property (@(posedge HCLK) disable iff (!HRESETn) push |-> !buffer_full);

	// CRC unit only takes a real entry
	assert property (@(posedge HCLK) disable iff (!HRESETn) pop |-> !buffer_empty);

endmodule

// ==== crc_unit.sv ====
/*
  Byte-serial CRC engine with INIT, POL and IDR registers
  Polynomial width 32/16/8/7, one byte per cycle, reset_chain aborts work in progress
*/
`timescale 1ns/1ps

module crc_unit
(
	input  logic                    HCLK,
	input  logic                    HRESETn,
	input  crc_ahb_pkg::crc_cfg_t   cfg,
	input  crc_ahb_pkg::crc_word_t  bus_wr,
	input  logic                    crc_init_en,
	input  logic                    crc_idr_en,
	input  logic                    crc_poly_en,
	input  logic                    reset_chain,
	input  crc_ahb_pkg::crc_entry_t head,
	input  logic                    buffer_empty,
	output logic                    pop,
	output crc_ahb_pkg::crc_word_t  crc_out,
	output crc_ahb_pkg::crc_word_t  crc_init_out,
	output crc_ahb_pkg::crc_word_t  crc_poly_out,
	output logic [7:0]              crc_idr_out,
	output logic                    reset_pending,
	output logic                    read_wait
);

	import crc_ahb_pkg::*;

	crc_word_t  init_q;
	crc_word_t  pol_q;
	logic [7:0] idr_q;
	crc_word_t  crc_q;

	// Engine state
	logic       busy_q;
	logic [1:0] byte_idx_q;
	logic [1:0] last_idx_q;
	crc_data_u  data_q;
	crc_word_t  crc_next;
	crc_word_t  crc_masked;

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	// Valid CRC bits for the selected width
	function automatic crc_word_t width_mask(crc_poly_size_e sz);
		case (sz)
			POLY_16: return 32'h0000_FFFF;
			POLY_8:  return 32'h0000_00FF;
			POLY_7:  return 32'h0000_007F;
			default: return 32'hFFFF_FFFF;
		endcase
	endfunction

	// Reversal inside a group is an XOR of the bit index
	function automatic crc_word_t reverse_in(crc_word_t w, crc_rev_in_e mode);
		crc_word_t r;
		int        flip;
		case (mode)
			REV_BYTE: flip = 7;
			REV_HALF: flip = 15;
			REV_WORD: flip = 31;
			default:  flip = 0;
		endcase
		for (int i = 0; i < 32; i++)
			r[i] = w[i ^ flip];
		return r;
	endfunction

	// One data byte, MSB first, shift left within the CRC width
	function automatic crc_word_t crc_byte(crc_word_t crc, logic [7:0] d,
	                                       crc_word_t pol, crc_poly_size_e sz);
		crc_word_t mask;
		crc_word_t c;
		logic      fb;
		mask = width_mask(sz);
		c    = crc & mask;
		for (int b = 7; b >= 0; b--)
		begin
			// Top bit of the active width
			case (sz)
				POLY_16: fb = c[15] ^ d[b];
				POLY_8:  fb = c[7] ^ d[b];
				POLY_7:  fb = c[6] ^ d[b];
				default: fb = c[31] ^ d[b];
			endcase
			c = (c << 1) & mask;
			if (fb)
				c = c ^ (pol & mask);
		end
		return c;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Registers written from the bus
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			init_q <= CRC_INIT_RESET;
			pol_q  <= CRC_POLY_RESET;
			idr_q  <= CRC_IDR_RESET;
		end
		else
		begin
			if (crc_init_en)
				init_q <= bus_wr;
			if (crc_poly_en)
				pol_q <= bus_wr;
			if (crc_idr_en)
				idr_q <= bus_wr[7:0];
		end
	end

	// Take the head entry as soon as the engine is free
	assign pop = !busy_q && !buffer_empty;

	assign crc_next = crc_byte(crc_q, data_q.bytes[byte_idx_q], pol_q, cfg.poly_size);

	// Control of the engine and the running CRC
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			busy_q     <= 1'b0;
			byte_idx_q <= 2'd0;
			crc_q      <= CRC_INIT_RESET;
		end
		else if (reset_chain)
		begin
			busy_q <= 1'b0;
			crc_q  <= init_q;
		end
		else if (pop)
		begin
			busy_q     <= 1'b1;
			byte_idx_q <= 2'd0;
		end
		else if (busy_q)
		begin
			crc_q <= crc_next;
			if (byte_idx_q == last_idx_q)
				busy_q <= 1'b0;
			else
				byte_idx_q <= byte_idx_q + 2'd1;
		end
	end

	// Entry payload, reversed once at pop
	always_ff @(posedge HCLK)
	begin
		if (pop)
		begin
			data_q.word <= reverse_in(head.data.word, cfg.rev_in);
			case (head.size)
				SIZE_BYTE: last_idx_q <= 2'd0;
				SIZE_HALF: last_idx_q <= 2'd1;
				default:   last_idx_q <= 2'd3;
			endcase
		end
	end

	// Output reversal spans all 32 bits
	assign crc_masked = crc_q & width_mask(cfg.poly_size);
	assign crc_out    = cfg.rev_out ? reverse_in(crc_masked, REV_WORD) : crc_masked;

	assign crc_init_out = init_q;
	assign crc_poly_out = pol_q;
	assign crc_idr_out  = idr_q;

	// Work still queued or in flight
	assign reset_pending = busy_q || !buffer_empty;
	assign read_wait     = busy_q || !buffer_empty;

	// Pop is a single pulse that starts the engine
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		pop && !reset_chain |=> busy_q && !pop);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the CRC peripheral testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_crc_ahb -f build.f -o tb_crc_ahb
status=0
./obj_dir/tb_crc_ahb > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "^Done: no errors$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed, exit status $status"
	exit 1
fi

// ==== tb_crc_model.svh ====
/*
  Reference model of the CRC peripheral, included inside the testbench module
  Needs crc_ahb_pkg imported before the include
*/
`ifndef TB_CRC_MODEL_SVH
`define TB_CRC_MODEL_SVH

// Number of CRC bits for a poly_size code
function automatic int model_width(crc_poly_size_e sz);
	case (sz)
		POLY_16: return 16;
		POLY_8:  return 8;
		POLY_7:  return 7;
		default: return 32;
	endcase
endfunction

// Ones in the low width bits
function automatic crc_word_t model_mask(int width);
	crc_word_t m;
	m = '0;
	for (int i = 0; i < width; i++)
		m[5'(i)] = 1'b1;
	return m;
endfunction

// Mirror the bits inside each group of grp bits
function automatic crc_word_t model_reflect(crc_word_t w, int grp);
	crc_word_t r;
	r = w;
	for (int base = 0; base < 32; base += grp)
		for (int k = 0; k < grp; k++)
			r[5'(base + k)] = w[5'(base + grp - 1 - k)];
	return r;
endfunction

function automatic crc_word_t model_rev_in(crc_word_t w, crc_rev_in_e mode);
	case (mode)
		REV_BYTE: return model_reflect(w, 8);
		REV_HALF: return model_reflect(w, 16);
		REV_WORD: return model_reflect(w, 32);
		default:  return w;
	endcase
endfunction

// One DR write into the running CRC, bytes from lane 0 upward, each MSB first
function automatic crc_word_t model_feed(crc_word_t state, crc_word_t data,
	crc_bus_size_e size, crc_cfg_t cfg, crc_word_t pol);
	crc_word_t w;
	crc_word_t mask;
	int        width;
	int        nbytes;
	logic      fb;
	width  = model_width(cfg.poly_size);
	mask   = model_mask(width);
	w      = model_rev_in(data, cfg.rev_in);
	nbytes = (size == SIZE_BYTE) ? 1 : (size == SIZE_HALF) ? 2 : 4;
	state  = state & mask;
	for (int n = 0; n < nbytes; n++)
		for (int b = 7; b >= 0; b--)
		begin
			// Feedback from the top bit of the active width
			fb    = state[5'(width - 1)] ^ w[5'(8 * n + b)];
			state = (state << 1) & mask;
			if (fb)
				state = state ^ (pol & mask);
		end
	return state;
endfunction

// Value a DR read returns
function automatic crc_word_t model_dr(crc_word_t state, crc_cfg_t cfg);
	crc_word_t v;
	v = state & model_mask(model_width(cfg.poly_size));
	return cfg.rev_out ? model_reflect(v, 32) : v;
endfunction

`endif

// ==== tb_crc_ahb.sv ====
/*
  Testbench of crc_ahb_top as the only slave of one master with HREADY held high
  Transfers are not pipelined since each address phase waits for the previous data phase
*/
`timescale 1ns/1ps

module tb_crc_ahb;

	import crc_ahb_pkg::*;

	`include "tb_crc_model.svh"

	localparam int SEED     = 12051;
	localparam int NUM_SEQ  = 200;
	localparam int MAX_DATA = 8;
	// Worst-case random sequences plus 225 directed transfers
	localparam int NUM_OPS        = NUM_SEQ * (MAX_DATA + 4) + 225;
	localparam int TIMEOUT_CYCLES = NUM_OPS * 16 + 200;
	localparam logic [1:0] HTRANS_IDLE = 2'b00;

	logic       HCLK;
	logic       HRESETn;
	logic       HSElx;
	crc_word_t  HADDR;
	logic [1:0] HTRANS;
	logic       HWRITE;
	logic [2:0] HSIZE;
	crc_word_t  HWDATA;
	logic       HREADY;
	crc_word_t  HRDATA;
	logic       HREADYOUT;
	logic       HRESP;

	// Model copies of the peripheral registers
	crc_cfg_t   m_cfg;
	crc_word_t  m_init;
	crc_word_t  m_pol;
	crc_word_t  m_state;
	logic [7:0] m_idr;

	int cycle_count  = 0;
	int stall_cycles = 0;

	crc_ahb_top #(
		.BUF_DEPTH (2)
	) u_crc_ahb_top
	(
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.HSElx     (HSElx),
		.HADDR     (HADDR),
		.HTRANS    (HTRANS),
		.HWRITE    (HWRITE),
		.HSIZE     (HSIZE),
		.HWDATA    (HWDATA),
		.HREADY    (HREADY),
		.HRDATA    (HRDATA),
		.HREADYOUT (HREADYOUT),
		.HRESP     (HRESP)
	);

	initial
	begin
		HCLK = 1'b0;
		forever #5 HCLK = ~HCLK;
	end

	//////////////////////////////////////////////////////////////////////
	// Failure handling and compares
	//////////////////////////////////////////////////////////////////////

	task automatic abort_run();
		$display("Done: errors found");
		$fatal(1, "Simulation stopped on first failure");
	endtask

	task automatic check_word(string name, crc_word_t got, crc_word_t exp);
		if (got !== exp)
		begin
			$display("Error: %s got %h, expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_resp(logic got);
		if (got !== HRESP_OKAY)
		begin
			$display("Error: HRESP got %h, expected %h", got, HRESP_OKAY);
			abort_run();
		end
	endtask

	// Run length guard
	always @(posedge HCLK)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout, the run passed %0d cycles without finishing", TIMEOUT_CYCLES);
			abort_run();
		end
	end

	//////////////////////////////////////////////////////////////////////
	// AHB master
	//////////////////////////////////////////////////////////////////////

	// Address phase then data phase until HREADYOUT is seen high at a negedge
	task automatic ahb_write_raw(logic sel, logic [1:0] trans, logic [2:0] idx,
		crc_word_t data, crc_bus_size_e size);
		@(posedge HCLK);
		HSElx  <= sel;
		HTRANS <= trans;
		HWRITE <= 1'b1;
		HADDR  <= {27'h0, idx, 2'b00};
		HSIZE  <= {1'b0, size};
		@(posedge HCLK);
		HSElx  <= 1'b0;
		HTRANS <= HTRANS_IDLE;
		HWDATA <= data;
		@(negedge HCLK);
		while (!HREADYOUT)
		begin
			stall_cycles++;
			@(negedge HCLK);
		end
		check_resp(HRESP);
	endtask

	task automatic ahb_read(logic [2:0] idx, output crc_word_t data);
		@(posedge HCLK);
		HSElx  <= 1'b1;
		HTRANS <= HTRANS_NONSEQ;
		HWRITE <= 1'b0;
		HADDR  <= {27'h0, idx, 2'b00};
		HSIZE  <= 3'b010;
		@(posedge HCLK);
		HSElx  <= 1'b0;
		HTRANS <= HTRANS_IDLE;
		@(negedge HCLK);
		while (!HREADYOUT)
			@(negedge HCLK);
		// HRDATA is steady here until the closing edge
		data = HRDATA;
		check_resp(HRESP);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Model tracking
	//////////////////////////////////////////////////////////////////////

	// Selected NONSEQ write that the model follows by the register rules
	task automatic bus_write(logic [2:0] idx, crc_word_t data, crc_bus_size_e size);
		ahb_write_raw(1'b1, HTRANS_NONSEQ, idx, data, size);
		case (idx)
			CRC_DR:   m_state = model_feed(m_state, data, size, m_cfg, m_pol);
			CRC_IDR:  m_idr = data[7:0];
			CRC_CR:
			begin
				m_cfg = crc_cfg_t'(data[7:3]);
				// Bit 0 restarts the chain from INIT
				if (data[0])
					m_state = m_init;
			end
			CRC_INIT: m_init = data;
			CRC_POL:  m_pol = data;
			default:  ;
		endcase
	endtask

	function automatic crc_word_t expected_read(logic [2:0] idx);
		case (idx)
			CRC_DR:   return model_dr(m_state, m_cfg);
			CRC_IDR:  return {24'h0, m_idr};
			CRC_CR:   return {24'h0, m_cfg, 3'b000};
			CRC_INIT: return m_init;
			CRC_POL:  return m_pol;
			default:  return '0;
		endcase
	endfunction

	task automatic read_check(logic [2:0] idx, string name);
		crc_word_t got;
		ahb_read(idx, got);
		check_word(name, got, expected_read(idx));
	endtask

	task automatic read_all_regs();
		read_check(CRC_POL, "POL");
		read_check(CRC_INIT, "INIT");
		read_check(CRC_IDR, "IDR");
		read_check(CRC_CR, "CR");
		read_check(CRC_DR, "DR");
	endtask

	// CR with chain reset and random data writes before the final DR read
	task automatic crc_sequence(logic [4:0] cfg_bits, int n_data);
		crc_bus_size_e size;
		// CR bits 2 and 1 are unused and get noise
		bus_write(CRC_CR, {24'h0, cfg_bits, 2'($urandom), 1'b1}, SIZE_WORD);
		for (int i = 0; i < n_data; i++)
		begin
			size = crc_bus_size_e'(2'($urandom_range(2, 0)));
			bus_write(CRC_DR, $urandom, size);
		end
		read_check(CRC_DR, "DR");
	endtask

	// Writes that must be ignored and leave the model alone
	task automatic ignored_writes(logic sel, logic [1:0] trans);
		ahb_write_raw(sel, trans, CRC_DR, $urandom, SIZE_WORD);
		ahb_write_raw(sel, trans, CRC_IDR, $urandom, SIZE_WORD);
		ahb_write_raw(sel, trans, CRC_CR, $urandom, SIZE_WORD);
		ahb_write_raw(sel, trans, CRC_INIT, $urandom, SIZE_WORD);
		ahb_write_raw(sel, trans, CRC_POL, $urandom, SIZE_WORD);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		int stalls_before;
		HRESETn = 1'b0;
		HSElx   = 1'b0;
		HADDR   = '0;
		HTRANS  = HTRANS_IDLE;
		HWRITE  = 1'b0;
		HSIZE   = 3'b010;
		HWDATA  = '0;
		HREADY  = 1'b1;
		void'($urandom(SEED));
		m_cfg   = '0;
		m_init  = CRC_INIT_RESET;
		m_pol   = CRC_POLY_RESET;
		m_idr   = CRC_IDR_RESET;
		m_state = CRC_INIT_RESET;
		repeat (3) @(posedge HCLK);
		HRESETn <= 1'b1;

		// Reset values
		read_all_regs();

		// Register read-back
		for (int i = 0; i < 20; i++)
		begin
			bus_write(CRC_IDR, $urandom, SIZE_WORD);
			bus_write(CRC_POL, $urandom, SIZE_WORD);
			bus_write(CRC_INIT, $urandom, SIZE_WORD);
			bus_write(CRC_CR, $urandom, SIZE_WORD);
			read_all_regs();
		end

		// Random CRC runs where the low CR bits sweep every width and reversal
		for (int s = 0; s < NUM_SEQ; s++)
		begin
			bus_write(CRC_POL, $urandom, SIZE_WORD);
			bus_write(CRC_INIT, $urandom, SIZE_WORD);
			crc_sequence(5'(s), int'($urandom_range(MAX_DATA, 1)));
		end

		// Back-to-back words overrun the engine so that a full buffer stalls the bus
		bus_write(CRC_POL, CRC_POLY_RESET, SIZE_WORD);
		bus_write(CRC_INIT, CRC_INIT_RESET, SIZE_WORD);
		bus_write(CRC_CR, 32'h0000_0001, SIZE_WORD);
		stalls_before = stall_cycles;
		for (int i = 0; i < 8; i++)
			bus_write(CRC_DR, $urandom, SIZE_WORD);
		if (stall_cycles == stalls_before)
		begin
			$display("Buffer never filled, no wait state during back-to-back DR writes");
			abort_run();
		end
		read_check(CRC_DR, "DR");

		// INIT update behind pending data waits for the engine
		bus_write(CRC_CR, {24'h0, 5'($urandom), 3'b001}, SIZE_WORD);
		for (int i = 0; i < 3; i++)
			bus_write(CRC_DR, $urandom, SIZE_WORD);
		stalls_before = stall_cycles;
		bus_write(CRC_INIT, $urandom, SIZE_WORD);
		if (stall_cycles == stalls_before)
		begin
			$display("INIT write finished while DR data was still pending");
			abort_run();
		end
		read_check(CRC_DR, "DR");
		read_check(CRC_INIT, "INIT");
		crc_sequence(5'($urandom), 4);

		// Unselected and IDLE transfers
		ignored_writes(1'b0, HTRANS_NONSEQ);
		ignored_writes(1'b1, HTRANS_IDLE);
		read_all_regs();

		$display("Done: no errors");
		$finish;
	end

endmodule
